//--- Makefile
SRCS := $(wildcard src/*.sv src/*.svh test/*.sv test/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vtb_rename_core: $(SRCS) project.f
	verilator --binary -Wno-fatal --timescale 1ns/1ns --top-module tb_rename_core \
		-f project.f -Mdir obj_dir -o Vtb_rename_core

run: obj_dir/Vtb_rename_core
	obj_dir/Vtb_rename_core | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- project.f
+incdir+src
+incdir+test
src/rename_pkg.sv
src/rename_ifs.sv
src/rename_stage.sv
src/free_list.sv
src/reorder_buffer.sv
src/retired_rename_table.sv
src/rename_core.sv
test/tb_rename_core.sv

//--- src/free_list.sv
`timescale 1ns/1ns
`include "rename_defs.svh"

module free_list (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,

    output rename_pkg::phys_reg_t free_preg,
    output logic                  free_empty,

    dispatch_if.sink              disp,
    commit_if.sink                commit
);

    localparam int IDX_W = $clog2(rename_pkg::FREE_DEPTH);

    // Ring of free tags
    rename_pkg::phys_reg_t ring [rename_pkg::FREE_DEPTH];

    // Pointers carry one extra wrap bit
    logic [IDX_W:0] head;
    logic [IDX_W:0] tail;
    // Head position as seen by retired instructions only
    logic [IDX_W:0] retire_head;

    logic take;
    logic give;

    assign take = disp.fire && disp.has_rd;
    assign give = commit.valid && commit.has_rd;

    assign free_preg  = ring[head[IDX_W-1:0]];
    assign free_empty = (head == tail);

    always_ff @(posedge clk) begin
        if (rst) begin
            // Tags above the identity map, in order
            for (int i = 0; i < rename_pkg::FREE_DEPTH; i++) begin
                ring[i] <= rename_pkg::phys_reg_t'(`ARCH_REGS + i);
            end
            head        <= '0;
            // Ring starts full
            tail        <= {1'b1, {IDX_W{1'b0}}};
            retire_head <= '0;
        end
        else begin
            if (flush) begin
                // Tags taken by squashed instructions become free again
                head <= retire_head;
            end
            else if (take) begin
                head <= head + 1'b1;
            end

            if (give) begin
                ring[tail[IDX_W-1:0]] <= commit.old_preg;
                tail                  <= tail + 1'b1;
                retire_head           <= retire_head + 1'b1;
            end
        end
    end

endmodule : free_list

//--- src/rename_core.sv
`timescale 1ns/1ns
`include "rename_defs.svh"

module rename_core (
    input  logic                  clk,
    input  logic                  rst,

    // Dispatch
    input  logic                  disp_valid,
    input  rename_pkg::arch_reg_t disp_rd,
    input  logic                  disp_has_rd,
    input  rename_pkg::arch_reg_t disp_rs1,
    input  rename_pkg::arch_reg_t disp_rs2,
    output logic                  disp_ready,
    output rename_pkg::phys_reg_t disp_prs1,
    output rename_pkg::phys_reg_t disp_prs2,
    output rename_pkg::phys_reg_t disp_prd,
    output rename_pkg::rob_id_t   disp_rob_id,

    // Completion
    input  logic                  done_valid,
    input  rename_pkg::rob_id_t   done_rob_id,
    input  logic                  done_mispredict,

    // Commit
    output logic                  commit_valid,
    output rename_pkg::arch_reg_t commit_rd,
    output rename_pkg::phys_reg_t commit_prd,
    output rename_pkg::phys_reg_t commit_freed_preg,
    output logic                  flush
);

    dispatch_if disp_bus ();
    commit_if   commit_bus ();

    rename_pkg::phys_reg_t free_preg;
    logic                  free_empty;
    logic                  rob_full;
    rename_pkg::phys_reg_t retired_map [`ARCH_REGS];

    assign disp_prd          = disp_bus.new_preg;
    assign commit_valid      = commit_bus.valid;
    assign commit_rd         = commit_bus.rd;
    assign commit_prd        = commit_bus.preg;
    assign commit_freed_preg = commit_bus.old_preg;

    rename_stage i_rename_stage (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (disp_valid),
        .disp_rd     (disp_rd),
        .disp_has_rd (disp_has_rd),
        .disp_rs1    (disp_rs1),
        .disp_rs2    (disp_rs2),
        .disp_ready  (disp_ready),
        .disp_prs1   (disp_prs1),
        .disp_prs2   (disp_prs2),
        .free_preg   (free_preg),
        .free_empty  (free_empty),
        .rob_full    (rob_full),
        .flush       (flush),
        .retired_map (retired_map),
        .disp        (disp_bus),
        .commit      (commit_bus)
    );

    free_list i_free_list (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .free_preg  (free_preg),
        .free_empty (free_empty),
        .disp       (disp_bus),
        .commit     (commit_bus)
    );

    reorder_buffer i_reorder_buffer (
        .clk             (clk),
        .rst             (rst),
        .done_valid      (done_valid),
        .done_rob_id     (done_rob_id),
        .done_mispredict (done_mispredict),
        .rob_full        (rob_full),
        .next_rob_id     (disp_rob_id),
        .flush           (flush),
        .disp            (disp_bus),
        .commit          (commit_bus)
    );

    retired_rename_table i_retired_rename_table (
        .clk         (clk),
        .rst         (rst),
        .commit      (commit_bus),
        .retired_map (retired_map)
    );

endmodule : rename_core

//--- src/rename_defs.svh
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Architectural register count for RV32I
`define ARCH_REGS 32

// Physical tags shared by all speculative and committed mappings
`define PHYS_REGS 64

// In-flight instruction window
`define ROB_DEPTH 8

`endif

//--- src/rename_ifs.sv
`timescale 1ns/1ns

// Accepted dispatch, one instruction per cycle
interface dispatch_if;
    logic                  fire;
    rename_pkg::arch_reg_t rd;
    logic                  has_rd;
    rename_pkg::phys_reg_t new_preg;
    rename_pkg::phys_reg_t old_preg;

    modport source (output fire, rd, has_rd, new_preg, old_preg);
    modport sink   (input  fire, rd, has_rd, new_preg, old_preg);
endinterface : dispatch_if

// Retirement of the oldest finished instruction
interface commit_if;
    logic                  valid;
    rename_pkg::arch_reg_t rd;
    logic                  has_rd;
    rename_pkg::phys_reg_t preg;
    rename_pkg::phys_reg_t old_preg;

    modport source (output valid, rd, has_rd, preg, old_preg);
    modport sink   (input  valid, rd, has_rd, preg, old_preg);
endinterface : commit_if

//--- src/rename_pkg.sv
`include "rename_defs.svh"

package rename_pkg;

    // Architectural register index
    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;

    // Physical register tag
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_t;

    // Reorder buffer slot index
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_id_t;

    // Tags not covered by the initial identity map start out free
    localparam int FREE_DEPTH = `PHYS_REGS - `ARCH_REGS;

    // One in-flight instruction
    typedef struct packed {
        arch_reg_t rd;
        logic      has_rd;
        // Tag given to rd at dispatch
        phys_reg_t new_preg;
        // Tag rd mapped to before, freed at retirement
        phys_reg_t old_preg;
        logic      done;
        logic      mispredict;
    } rob_entry_t;

endpackage : rename_pkg

//--- src/rename_stage.sv
`timescale 1ns/1ns
`include "rename_defs.svh"

module rename_stage (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  disp_valid,
    input  rename_pkg::arch_reg_t disp_rd,
    input  logic                  disp_has_rd,
    input  rename_pkg::arch_reg_t disp_rs1,
    input  rename_pkg::arch_reg_t disp_rs2,
    output logic                  disp_ready,
    output rename_pkg::phys_reg_t disp_prs1,
    output rename_pkg::phys_reg_t disp_prs2,

    input  rename_pkg::phys_reg_t free_preg,
    input  logic                  free_empty,
    input  logic                  rob_full,
    input  logic                  flush,
    input  rename_pkg::phys_reg_t retired_map [`ARCH_REGS],

    dispatch_if.source            disp,
    commit_if.sink                commit
);

    // Speculative arch to phys map
    rename_pkg::phys_reg_t spec_map [`ARCH_REGS];

    logic fire;

    // Stall on a full window, on a missing tag for rd, and during recovery
    always_comb begin
        disp_ready = 1'b1;
        if (rob_full) begin
            disp_ready = 1'b0;
        end
        if (disp_has_rd && free_empty) begin
            disp_ready = 1'b0;
        end
        if (flush) begin
            disp_ready = 1'b0;
        end
    end

    assign fire = disp_valid && disp_ready;

    // Sources see the map before this instruction's own rd update
    assign disp_prs1 = spec_map[disp_rs1];
    assign disp_prs2 = spec_map[disp_rs2];

    assign disp.fire     = fire;
    assign disp.rd       = disp_rd;
    assign disp.has_rd   = disp_has_rd;
    assign disp.new_preg = free_preg;
    assign disp.old_preg = spec_map[disp_rd];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                spec_map[i] <= rename_pkg::phys_reg_t'(i);
            end
        end
        else if (flush) begin
            // Fall back to the committed state
            for (int i = 0; i < `ARCH_REGS; i++) begin
                spec_map[i] <= retired_map[i];
            end
        end
        else if (fire && disp_has_rd) begin
            spec_map[disp_rd] <= free_preg;
        end
    end

endmodule : rename_stage

//--- src/reorder_buffer.sv
`timescale 1ns/1ns
`include "rename_defs.svh"

module reorder_buffer (
    input  logic                clk,
    input  logic                rst,

    input  logic                done_valid,
    input  rename_pkg::rob_id_t done_rob_id,
    input  logic                done_mispredict,

    output logic                rob_full,
    output rename_pkg::rob_id_t next_rob_id,
    output logic                flush,

    dispatch_if.sink            disp,
    commit_if.source            commit
);

    localparam int CNT_W = $clog2(`ROB_DEPTH) + 1;

    rename_pkg::rob_entry_t entries [`ROB_DEPTH];

    rename_pkg::rob_id_t head;
    rename_pkg::rob_id_t tail;
    logic [CNT_W-1:0]    count;

    rename_pkg::rob_entry_t head_entry;
    logic                   retire;

    assign head_entry = entries[head];

    assign rob_full    = (count == CNT_W'(`ROB_DEPTH));
    assign next_rob_id = tail;

    // Oldest entry retires once finished, never during recovery
    assign retire = (count != '0) && head_entry.done && !flush;

    assign commit.valid    = retire;
    assign commit.rd       = head_entry.rd;
    assign commit.has_rd   = head_entry.has_rd;
    assign commit.preg     = head_entry.new_preg;
    assign commit.old_preg = head_entry.old_preg;

    // Entry payload
    always_ff @(posedge clk) begin
        if (disp.fire) begin
            entries[tail] <= '{
                rd:         disp.rd,
                has_rd:     disp.has_rd,
                new_preg:   disp.new_preg,
                old_preg:   disp.old_preg,
                done:       1'b0,
                mispredict: 1'b0
            };
        end
        // Results arrive in any order
        if (done_valid) begin
            entries[done_rob_id].done       <= 1'b1;
            entries[done_rob_id].mispredict <= done_mispredict;
        end
    end

    // Pointers, occupancy and recovery pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            flush <= 1'b0;
        end
        else begin
            // Recovery follows the retirement of a mispredicted branch
            flush <= retire && head_entry.mispredict;

            if (flush) begin
                head  <= '0;
                tail  <= '0;
                count <= '0;
            end
            else begin
                if (disp.fire) begin
                    tail <= tail + 1'b1;
                end
                if (retire) begin
                    head <= head + 1'b1;
                end
                case ({disp.fire, retire})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

endmodule : reorder_buffer

//--- src/retired_rename_table.sv
`timescale 1ns/1ns
`include "rename_defs.svh"

module retired_rename_table (
    input  logic                  clk,
    input  logic                  rst,

    commit_if.sink                commit,

    output rename_pkg::phys_reg_t retired_map [`ARCH_REGS]
);

    // Only retired results update the committed map
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                retired_map[i] <= rename_pkg::phys_reg_t'(i);
            end
        end
        else if (commit.valid && commit.has_rd) begin
            retired_map[commit.rd] <= commit.preg;
        end
    end

endmodule : retired_rename_table

//--- test/tb_rename_table.svh
// name, op, rd, has_rd, rs1, rs2, done id, mispredict
//   ready, prs1, prs2, prd, rob id, commit kind, commit rd, commit prd, freed tag, flush

// Renaming right after reset
add_row("after_reset",       OP_DISP,  1, 1,  2,  3, 0, 0,
        1,  2,  3, 32, 0, NO_COMMIT, 0, 0, 0, 0);
add_row("raw_dependency",    OP_DISP,  2, 1,  1,  0, 0, 0,
        1, 32,  0, 33, 1, NO_COMMIT, 0, 0, 0, 0);
add_row("same_src_dst",      OP_DISP,  2, 1,  2,  2, 0, 0,
        1, 33, 33, 34, 2, NO_COMMIT, 0, 0, 0, 0);
add_row("no_dest",           OP_DISP,  0, 0,  1,  2, 0, 0,
        1, 32, 34,  0, 3, NO_COMMIT, 0, 0, 0, 0);
add_row("tag_not_consumed",  OP_DISP,  3, 1,  0,  0, 0, 0,
        1,  0,  0, 35, 4, NO_COMMIT, 0, 0, 0, 0);

// Out of order completion and in order retirement
add_row("done_2",            OP_DONE,  0, 0,  0,  0, 2, 0,
        1,  0,  0,  0, 0, NO_COMMIT, 0, 0, 0, 0);
add_row("done_0",            OP_DONE,  0, 0,  0,  0, 0, 0,
        1,  0,  0,  0, 0, NO_COMMIT, 0, 0, 0, 0);
add_row("done_1_commit_0",   OP_DONE,  0, 0,  0,  0, 1, 0,
        1,  0,  0,  0, 0, COMMIT_RD, 1, 32, 1, 0);
add_row("commit_1",          OP_IDLE,  0, 0,  0,  0, 0, 0,
        1,  0,  0,  0, 0, COMMIT_RD, 2, 33, 2, 0);
add_row("commit_2",          OP_IDLE,  0, 0,  0,  0, 0, 0,
        1,  0,  0,  0, 0, COMMIT_RD, 2, 34, 33, 0);
add_row("done_3_no_commit",  OP_DONE,  0, 0,  0,  0, 3, 0,
        1,  0,  0,  0, 0, NO_COMMIT, 0, 0, 0, 0);
add_row("done_4_commit_3",   OP_DONE,  0, 0,  0,  0, 4, 0,
        1,  0,  0,  0, 0, COMMIT_NO_RD, 0, 0, 0, 0);
add_row("commit_4",          OP_IDLE,  0, 0,  0,  0, 0, 0,
        1,  0,  0,  0, 0, COMMIT_RD, 3, 35, 3, 0);

// Eight uncommitted dispatches fill the window
add_row("fill_0",            OP_DISP,  4, 1,  3,  0, 0, 0,
        1, 35,  0, 36, 5, NO_COMMIT, 0, 0, 0, 0);
add_row("fill_1",            OP_DISP,  5, 1,  4,  1, 0, 0,
        1, 36, 32, 37, 6, NO_COMMIT, 0, 0, 0, 0);
add_row("fill_2",            OP_DISP,  6, 1,  5,  2, 0, 0,
        1, 37, 34, 38, 7, NO_COMMIT, 0, 0, 0, 0);
add_row("fill_3",            OP_DISP,  7, 1,  6,  3, 0, 0,
        1, 38, 35, 39, 0, NO_COMMIT, 0, 0, 0, 0);
add_row("fill_4",            OP_DISP,  8, 1,  7,  0, 0, 0,
        1, 39,  0, 40, 1, NO_COMMIT, 0, 0, 0, 0);
add_row("fill_5",            OP_DISP,  9, 1,  8,  0, 0, 0,
        1, 40,  0, 41, 2, NO_COMMIT, 0, 0, 0, 0);
add_row("fill_6",            OP_DISP, 10, 1,  9,  0, 0, 0,
        1, 41,  0, 42, 3, NO_COMMIT, 0, 0, 0, 0);
add_row("fill_7",            OP_DISP, 11, 1, 10,  0, 0, 0,
        1, 42,  0, 43, 4, NO_COMMIT, 0, 0, 0, 0);
add_row("full_stall",        OP_DISP, 12, 1, 11,  0, 0, 0,
        0, 43,  0, 44, 5, NO_COMMIT, 0, 0, 0, 0);
add_row("full_done_5",       OP_BOTH, 12, 1, 11,  0, 5, 0,
        0, 43,  0, 44, 5, NO_COMMIT, 0, 0, 0, 0);
add_row("full_commit_5",     OP_DISP, 12, 1, 11,  0, 0, 0,
        0, 43,  0, 44, 5, COMMIT_RD, 4, 36, 4, 0);
add_row("full_accept",       OP_DISP, 12, 1, 11,  0, 0, 0,
        1, 43,  0, 44, 5, NO_COMMIT, 0, 0, 0, 0);

// Mispredicted branch in slot 6 squashes everything younger
add_row("mispredict_done",   OP_DONE,  0, 0,  0,  0, 6, 1,
        0,  0,  0,  0, 0, NO_COMMIT, 0, 0, 0, 0);
add_row("mispredict_commit", OP_IDLE,  0, 0,  0,  0, 0, 0,
        0,  0,  0,  0, 0, COMMIT_RD, 5, 37, 5, 0);
add_row("flush_pulse",       OP_IDLE,  0, 0,  0,  0, 0, 0,
        0,  0,  0,  0, 0, NO_COMMIT, 0, 0, 0, 1);
add_row("restored_map",      OP_DISP,  5, 1,  5,  4, 0, 0,
        1, 37, 36, 38, 0, NO_COMMIT, 0, 0, 0, 0);
add_row("squashed_undone",   OP_DISP,  7, 1,  6, 12, 0, 0,
        1,  6, 12, 39, 1, NO_COMMIT, 0, 0, 0, 0);
add_row("post_done_0",       OP_DONE,  0, 0,  0,  0, 0, 0,
        1,  0,  0,  0, 0, NO_COMMIT, 0, 0, 0, 0);
add_row("post_done_1",       OP_DONE,  0, 0,  0,  0, 1, 0,
        1,  0,  0,  0, 0, COMMIT_RD, 5, 38, 37, 0);
add_row("post_commit_1",     OP_IDLE,  0, 0,  0,  0, 0, 0,
        1,  0,  0,  0, 0, COMMIT_RD, 7, 39, 7, 0);

//--- test/tb_rename_core.sv
`timescale 1ns/1ns

module tb_rename_core;

    // Bit 0 of a row operation dispatches and bit 1 completes
    localparam int OP_IDLE = 0;
    localparam int OP_DISP = 1;
    localparam int OP_DONE = 2;
    localparam int OP_BOTH = 3;

    // Expected commit kind
    localparam int NO_COMMIT    = 0;
    localparam int COMMIT_RD    = 1;
    localparam int COMMIT_NO_RD = 2;

    typedef struct {
        string name;
        int    op;
        int    rd, has_rd, rs1, rs2, done_id, mispredict;
        int    ready, prs1, prs2, prd, rob_id;
        int    commit, commit_rd, commit_prd, freed, flush;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  disp_valid;
    rename_pkg::arch_reg_t disp_rd;
    logic                  disp_has_rd;
    rename_pkg::arch_reg_t disp_rs1;
    rename_pkg::arch_reg_t disp_rs2;
    logic                  disp_ready;
    rename_pkg::phys_reg_t disp_prs1;
    rename_pkg::phys_reg_t disp_prs2;
    rename_pkg::phys_reg_t disp_prd;
    rename_pkg::rob_id_t   disp_rob_id;
    logic                  done_valid;
    rename_pkg::rob_id_t   done_rob_id;
    logic                  done_mispredict;
    logic                  commit_valid;
    rename_pkg::arch_reg_t commit_rd;
    rename_pkg::phys_reg_t commit_prd;
    rename_pkg::phys_reg_t commit_freed_preg;
    logic                  flush;

    row_t table_rows[$];
    int   cycles;
    int   limit;

    rename_core i_rename_core (.*);

    always #10 clk = ~clk;

    // Ends a hung run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: the stimulus table did not finish within %0d cycles", limit);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    function automatic void add_row(
        input string name, input int op,
        input int rd, input int has_rd, input int rs1, input int rs2,
        input int done_id, input int mispredict,
        input int ready, input int prs1, input int prs2, input int prd, input int rob_id,
        input int commit, input int c_rd, input int c_prd, input int c_freed, input int pulse
    );
        table_rows.push_back('{name, op, rd, has_rd, rs1, rs2, done_id, mispredict,
                               ready, prs1, prs2, prd, rob_id,
                               commit, c_rd, c_prd, c_freed, pulse});
    endfunction

    function automatic void load_table();
        `include "tb_rename_table.svh"
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: %s expected %0d, actual %0d", test, field, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic drive_row(input row_t r);
        @(posedge clk);
        disp_valid      <= (r.op & OP_DISP) != 0;
        disp_rd         <= rename_pkg::arch_reg_t'(r.rd);
        disp_has_rd     <= r.has_rd != 0;
        disp_rs1        <= rename_pkg::arch_reg_t'(r.rs1);
        disp_rs2        <= rename_pkg::arch_reg_t'(r.rs2);
        done_valid      <= (r.op & OP_DONE) != 0;
        done_rob_id     <= rename_pkg::rob_id_t'(r.done_id);
        done_mispredict <= r.mispredict != 0;
    endtask

    task automatic check_row(input row_t r);
        check_value(r.name, "disp_ready", r.ready, disp_ready);
        check_value(r.name, "flush", r.flush, flush);
        check_value(r.name, "commit_valid", r.commit != NO_COMMIT, commit_valid);
        if ((r.op & OP_DISP) != 0) begin
            check_value(r.name, "disp_prs1", r.prs1, disp_prs1);
            check_value(r.name, "disp_prs2", r.prs2, disp_prs2);
            check_value(r.name, "disp_rob_id", r.rob_id, disp_rob_id);
            // No tag is taken without rd
            if (r.has_rd != 0) begin
                check_value(r.name, "disp_prd", r.prd, disp_prd);
            end
        end
        if (r.commit == COMMIT_RD) begin
            check_value(r.name, "commit_rd", r.commit_rd, commit_rd);
            check_value(r.name, "commit_prd", r.commit_prd, commit_prd);
            check_value(r.name, "commit_freed_preg", r.freed, commit_freed_preg);
        end
    endtask

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        disp_valid      = 1'b0;
        disp_rd         = '0;
        disp_has_rd     = 1'b0;
        disp_rs1        = '0;
        disp_rs2        = '0;
        done_valid      = 1'b0;
        done_rob_id     = '0;
        done_mispredict = 1'b0;
        cycles          = 0;
        load_table();
        limit = 2 * table_rows.size() + 50;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        foreach (table_rows[i]) begin
            drive_row(table_rows[i]);
            // Combinational outputs have settled by the falling edge
            @(negedge clk);
            check_row(table_rows[i]);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule : tb_rename_core
